// ==== logic/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

	// dram side
	localparam int word_w = 32;
	localparam int addr_w = 32;
	localparam int dram_a_w = 12;

	// buffer side
	localparam int buf_a_w = 7;
	localparam int banks = 2;

	// words per buffer line
	localparam int input_words = 4;
	localparam int weight_words = 9;

	// column counter covers the longer line
	localparam int col_w = $clog2(weight_words);

	// kind input encoding
	localparam logic kind_input = 1'b0;
	localparam logic kind_weight = 1'b1;

	typedef logic [word_w-1:0] word_t;
	typedef logic [buf_a_w-1:0] buf_addr_t;
	typedef logic [col_w-1:0] col_t;

	// first word read sits in the top 32 bits
	typedef logic [input_words*word_w-1:0] input_line_t;
	typedef logic [weight_words*word_w-1:0] weight_line_t;

endpackage

`default_nettype wire

// ==== logic/dram_row_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_row_sequencer (
	input wire clk,
	input wire rst,
	input wire start,
	input wire kind,
	input wire [dma_pkg::addr_w-1:0] dram_addr_start,
	input wire [dma_pkg::addr_w-1:0] dram_addr_end,
	input wire dma_pkg::word_t dram_q,
	output logic ras_n,
	output logic cas_n,
	output logic [dma_pkg::dram_a_w-1:0] dram_a,
	output dma_pkg::word_t word,
	output logic line_start,
	output logic input_word_valid,
	output logic input_line_done,
	output logic weight_word_valid,
	output logic weight_line_done,
	output logic done
);

	typedef enum logic [2:0] {
		st_idle,
		st_activate,
		st_column,
		st_capture,
		st_write
	} state_t;

	state_t state;
	state_t state_next;

	logic [dma_pkg::addr_w-1:0] addr_q;
	dma_pkg::col_t col_q;
	dma_pkg::col_t col_last;
	logic last_line;
	logic read_q;
	logic valid_q;

	// index of the final column read in a line
	always_comb
	begin
		if (kind == dma_pkg::kind_weight)
			col_last = dma_pkg::col_t'(dma_pkg::weight_words - 1);
		else
			col_last = dma_pkg::col_t'(dma_pkg::input_words - 1);
	end

	// counter already points past the last word read
	assign last_line = addr_q[23:2] > dram_addr_end[23:2];

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
			begin
				if (start)
					state_next = st_activate;
			end
			st_activate:
				state_next = st_column;
			st_column:
			begin
				if (col_q == col_last)
					state_next = st_capture;
			end
			st_capture:
				state_next = st_write;
			st_write:
			begin
				if (last_line)
					state_next = st_idle;
				else
					state_next = st_activate;
			end
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			state <= st_idle;
		else
			state <= state_next;
	end

	// byte address and column position within the line
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			addr_q <= '0;
			col_q <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (start)
						addr_q <= dram_addr_start;
				end
				st_activate:
					col_q <= '0;
				st_column:
				begin
					// one word per column read
					addr_q <= addr_q + {{(dma_pkg::addr_w - 3){1'b0}}, 3'b100};
					col_q <= col_q + dma_pkg::col_t'(1);
				end
				default:
				begin
				end
			endcase
		end
	end

	// activate drives the row, column reads drive the zero-extended column
	assign ras_n = !(state == st_activate || state == st_column);
	assign cas_n = !(state == st_column);
	assign dram_a = (state == st_activate) ? addr_q[23:12] : {2'b00, addr_q[11:2]};

	// dram_q is valid the cycle after a column read
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			read_q <= 1'b0;
			valid_q <= 1'b0;
		end
		else
		begin
			read_q <= (state == st_column);
			valid_q <= read_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (read_q)
			word <= dram_q;
	end

	assign input_word_valid = valid_q && (kind == dma_pkg::kind_input);
	assign weight_word_valid = valid_q && (kind == dma_pkg::kind_weight);
	assign input_line_done = (state == st_write) && (kind == dma_pkg::kind_input);
	assign weight_line_done = (state == st_write) && (kind == dma_pkg::kind_weight);

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			line_start <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			line_start <= (state == st_idle) && start;
			done <= (state == st_write) && last_line;
		end
	end

endmodule

`default_nettype wire

// ==== logic/line_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_packer #(
	parameter type payload_t = dma_pkg::input_line_t,
	parameter int words = dma_pkg::input_words
) (
	input wire clk,
	input wire rst,
	input wire line_start,
	input wire word_valid,
	input wire line_done,
	input wire dma_pkg::word_t word,
	input wire bank,
	input wire dma_pkg::buf_addr_t buf_addr_start,
	output logic [dma_pkg::banks-1:0] cen,
	output logic [dma_pkg::banks-1:0] wen,
	output dma_pkg::buf_addr_t a [dma_pkg::banks],
	output payload_t di [dma_pkg::banks]
);

	logic [words*dma_pkg::word_w-1:0] line_q;
	logic [words*dma_pkg::word_w-1:0] line_next;
	dma_pkg::buf_addr_t buf_q;
	logic [dma_pkg::banks-1:0] hit;
	dma_pkg::buf_addr_t a_q [dma_pkg::banks];
	payload_t di_q [dma_pkg::banks];

	// new word enters at the bottom, so the first word ends on top
	assign line_next = {line_q[(words-1)*dma_pkg::word_w-1:0], word};

	always_ff @(posedge clk)
	begin
		if (word_valid)
			line_q <= line_next;
	end

	// buffer address for the next line
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			buf_q <= '0;
		else if (line_start)
			buf_q <= buf_addr_start;
		else if (line_done)
			buf_q <= buf_q + dma_pkg::buf_addr_t'(1);
	end

	// selected bank writes in the line_done cycle
	always_comb
	begin
		hit = '0;
		hit[bank] = line_done;
	end

	assign cen = ~hit;
	assign wen = ~hit;

	// last word arrives with line_done, so the line is taken from line_next
	always_comb
	begin
		for (int b = 0; b < dma_pkg::banks; b++)
		begin
			if (hit[b])
			begin
				a[b] = buf_q;
				di[b] = payload_t'(line_next);
			end
			else
			begin
				a[b] = a_q[b];
				di[b] = di_q[b];
			end
		end
	end

	// pins keep the last written address and line
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < dma_pkg::banks; b++)
		begin
			if (hit[b])
			begin
				a_q[b] <= buf_q;
				di_q[b] <= payload_t'(line_next);
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/buffer_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module buffer_dma (
	input wire clk,
	input wire rst,
	input wire start,
	input wire kind,
	input wire bank,
	input wire [dma_pkg::addr_w-1:0] dram_addr_start,
	input wire [dma_pkg::addr_w-1:0] dram_addr_end,
	input wire dma_pkg::buf_addr_t buf_addr_start,
	input wire dma_pkg::word_t dram_q,
	output logic done,
	output logic ras_n,
	output logic cas_n,
	output logic [dma_pkg::dram_a_w-1:0] dram_a,
	output logic [dma_pkg::banks-1:0] input_buffer_cen,
	output logic [dma_pkg::banks-1:0] input_buffer_wen,
	output dma_pkg::buf_addr_t input_buffer_a [dma_pkg::banks],
	output dma_pkg::input_line_t input_buffer_di [dma_pkg::banks],
	output logic [dma_pkg::banks-1:0] weight_buffer_cen,
	output logic [dma_pkg::banks-1:0] weight_buffer_wen,
	output dma_pkg::buf_addr_t weight_buffer_a [dma_pkg::banks],
	output dma_pkg::weight_line_t weight_buffer_di [dma_pkg::banks]
);

	dma_pkg::word_t word;
	logic line_start;
	logic input_word_valid;
	logic input_line_done;
	logic weight_word_valid;
	logic weight_line_done;

	dram_row_sequencer i_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.kind(kind),
		.dram_addr_start(dram_addr_start),
		.dram_addr_end(dram_addr_end),
		.dram_q(dram_q),
		.ras_n(ras_n),
		.cas_n(cas_n),
		.dram_a(dram_a),
		.word(word),
		.line_start(line_start),
		.input_word_valid(input_word_valid),
		.input_line_done(input_line_done),
		.weight_word_valid(weight_word_valid),
		.weight_line_done(weight_line_done),
		.done(done)
	);

	// 128-bit lines of four words
	line_packer #(
		.payload_t(dma_pkg::input_line_t),
		.words(dma_pkg::input_words)
	) i_input_packer (
		.clk(clk),
		.rst(rst),
		.line_start(line_start),
		.word_valid(input_word_valid),
		.line_done(input_line_done),
		.word(word),
		.bank(bank),
		.buf_addr_start(buf_addr_start),
		.cen(input_buffer_cen),
		.wen(input_buffer_wen),
		.a(input_buffer_a),
		.di(input_buffer_di)
	);

	// 288-bit lines of nine words
	line_packer #(
		.payload_t(dma_pkg::weight_line_t),
		.words(dma_pkg::weight_words)
	) i_weight_packer (
		.clk(clk),
		.rst(rst),
		.line_start(line_start),
		.word_valid(weight_word_valid),
		.line_done(weight_line_done),
		.word(word),
		.bank(bank),
		.buf_addr_start(buf_addr_start),
		.cen(weight_buffer_cen),
		.wen(weight_buffer_wen),
		.a(weight_buffer_a),
		.di(weight_buffer_di)
	);

endmodule

`default_nettype wire

// ==== dv/tb_buffer_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_buffer_dma;

	localparam int done_timeout = 200;

	logic clk;
	logic rst;
	logic start;
	logic kind;
	logic bank;
	logic [dma_pkg::addr_w-1:0] dram_addr_start;
	logic [dma_pkg::addr_w-1:0] dram_addr_end;
	dma_pkg::buf_addr_t buf_addr_start;
	dma_pkg::word_t dram_q;
	logic done;
	logic ras_n;
	logic cas_n;
	logic [dma_pkg::dram_a_w-1:0] dram_a;
	logic [dma_pkg::banks-1:0] input_buffer_cen;
	logic [dma_pkg::banks-1:0] input_buffer_wen;
	dma_pkg::buf_addr_t input_buffer_a [dma_pkg::banks];
	dma_pkg::input_line_t input_buffer_di [dma_pkg::banks];
	logic [dma_pkg::banks-1:0] weight_buffer_cen;
	logic [dma_pkg::banks-1:0] weight_buffer_wen;
	dma_pkg::buf_addr_t weight_buffer_a [dma_pkg::banks];
	dma_pkg::weight_line_t weight_buffer_di [dma_pkg::banks];

	// dram contents, transfers and expected writes from the data file
	dma_pkg::word_t dram_mem [logic [31:0]];
	logic t_kind [$];
	logic t_bank [$];
	dma_pkg::buf_addr_t t_buf [$];
	logic [31:0] t_start [$];
	logic [31:0] t_end [$];
	logic e_kind [$];
	logic e_bank [$];
	dma_pkg::buf_addr_t e_addr [$];
	dma_pkg::weight_line_t e_line [$];

	int mismatch_count = 0;
	int error_count = 0;
	int write_count = 0;
	int exp_idx = 0;
	logic wrote_now;
	logic wrote_prev;
	logic done_prev;
	logic [11:0] row_q;
	logic row_open;
	logic read_now;
	logic [31:0] rd_addr;
	dma_pkg::word_t q_next;
	bit run_ok;
	int tr;

	buffer_dma i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input string exp_v, input string act_v);
		$display("FAIL %0t %s expected %s actual %s", $time, name, exp_v, act_v);
		mismatch_count++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %0t %s", $time, msg);
		error_count++;
	endtask

	function automatic string buffer_name(input logic k);
		if (k)
			return "weight";
		else
			return "input";
	endfunction

	task automatic load_testdata();
		int fd;
		int n;
		string line;
		logic [7:0] tag;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [31:0] f5;
		dma_pkg::weight_line_t fl;
		fd = $fopen("dv/buffer_dma_testdata.txt", "r");
		if (fd == 0)
		begin
			report_error("cannot open dv/buffer_dma_testdata.txt");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			tag = (line.len() > 0) ? line.getc(0) : "#";
			case (tag)
				"M":
				begin
					n = $sscanf(line, "M %h %h", f1, f2);
					if (n != 2)
						report_error({"bad memory record: ", line});
					dram_mem[f1] = f2;
				end
				"T":
				begin
					n = $sscanf(line, "T %h %h %h %h %h", f1, f2, f3, f4, f5);
					if (n != 5)
						report_error({"bad transfer record: ", line});
					t_kind.push_back(f1[0]);
					t_bank.push_back(f2[0]);
					t_buf.push_back(f3[dma_pkg::buf_a_w-1:0]);
					t_start.push_back(f4);
					t_end.push_back(f5);
				end
				"E":
				begin
					n = $sscanf(line, "E %h %h %h %h", f1, f2, f3, fl);
					if (n != 4)
						report_error({"bad expected-line record: ", line});
					e_kind.push_back(f1[0]);
					e_bank.push_back(f2[0]);
					e_addr.push_back(f3[dma_pkg::buf_a_w-1:0]);
					e_line.push_back(fl);
				end
				"#", "\n", "\r", " ":
					;
				default:
					report_error({"unknown record in test data: ", line});
			endcase
		end
		$fclose(fd);
	endtask

	task automatic check_idle_outputs();
		if (input_buffer_cen !== 2'b11)
			report_mismatch("input_buffer_cen", "11", $sformatf("%b", input_buffer_cen));
		if (input_buffer_wen !== 2'b11)
			report_mismatch("input_buffer_wen", "11", $sformatf("%b", input_buffer_wen));
		if (weight_buffer_cen !== 2'b11)
			report_mismatch("weight_buffer_cen", "11", $sformatf("%b", weight_buffer_cen));
		if (weight_buffer_wen !== 2'b11)
			report_mismatch("weight_buffer_wen", "11", $sformatf("%b", weight_buffer_wen));
		if (ras_n !== 1'b1)
			report_mismatch("ras_n", "1", $sformatf("%b", ras_n));
		if (cas_n !== 1'b1)
			report_mismatch("cas_n", "1", $sformatf("%b", cas_n));
		if (done !== 1'b0)
			report_mismatch("done", "0", $sformatf("%b", done));
	endtask

	// compare one bank of one buffer with the next expected write
	task automatic check_port(input logic kind_b, input logic bank_b, input logic cen_b,
		input logic wen_b, input dma_pkg::buf_addr_t a_b, input dma_pkg::weight_line_t line_b);
		string pre;
		pre = $sformatf("%s_buffer", buffer_name(kind_b));
		if (cen_b !== wen_b)
			report_mismatch($sformatf("%s_wen[%0d]", pre, bank_b), $sformatf("%b", cen_b),
				$sformatf("%b", wen_b));
		if (cen_b === 1'b0)
		begin
			wrote_now = 1'b1;
			write_count++;
			if (exp_idx >= e_kind.size())
				report_error($sformatf("unexpected write on %s bank %0d", pre, bank_b));
			else
			begin
				if (e_kind[exp_idx] !== kind_b || e_bank[exp_idx] !== bank_b)
					report_mismatch("write target",
						$sformatf("%s bank %0d", buffer_name(e_kind[exp_idx]), e_bank[exp_idx]),
						$sformatf("%s bank %0d", buffer_name(kind_b), bank_b));
				if (e_addr[exp_idx] !== a_b)
					report_mismatch($sformatf("%s_a[%0d]", pre, bank_b),
						$sformatf("%h", e_addr[exp_idx]), $sformatf("%h", a_b));
				if (e_line[exp_idx] !== line_b)
					report_mismatch($sformatf("%s_di[%0d]", pre, bank_b),
						$sformatf("%h", e_line[exp_idx]), $sformatf("%h", line_b));
				exp_idx++;
			end
		end
	endtask

	task automatic run_transfer(input int idx, output bit ok);
		int writes_before;
		int words;
		int lines;
		int cyc;
		bit seen;
		writes_before = write_count;
		words = t_kind[idx] ? dma_pkg::weight_words : dma_pkg::input_words;
		lines = (int'(t_end[idx] - t_start[idx]) / 4 + 1) / words;
		@(posedge clk);
		#1;
		kind = t_kind[idx];
		bank = t_bank[idx];
		buf_addr_start = t_buf[idx];
		dram_addr_start = t_start[idx];
		dram_addr_end = t_end[idx];
		start = 1'b1;
		// second edge lands in the activate cycle
		repeat (2) @(posedge clk);
		#1;
		start = 1'b0;
		@(posedge clk);
		#1;
		// stray start during the column reads
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		seen = 1'b0;
		for (cyc = 0; cyc < done_timeout && !seen; cyc++)
		begin
			@(negedge clk);
			seen = (done === 1'b1);
		end
		if (!seen)
		begin
			report_error($sformatf("no done within %0d cycles on transfer %0d", done_timeout, idx));
			ok = 1'b0;
			return;
		end
		repeat (4)
		begin
			@(negedge clk);
			if (ras_n !== 1'b1)
				report_error($sformatf("DRAM access after done on transfer %0d", idx));
		end
		if (write_count - writes_before != lines)
			report_mismatch($sformatf("write count of transfer %0d", idx), $sformatf("%0d", lines),
				$sformatf("%0d", write_count - writes_before));
		ok = 1'b1;
	endtask

	// dram model with one cycle of read latency
	initial
	begin
		dram_q = '0;
		row_open = 1'b0;
		row_q = '0;
		q_next = '0;
		forever
		begin
			@(negedge clk);
			read_now = 1'b0;
			if (ras_n === 1'b0 && cas_n === 1'b1)
			begin
				row_q = dram_a;
				row_open = 1'b1;
			end
			else if (ras_n === 1'b0 && cas_n === 1'b0)
			begin
				read_now = 1'b1;
				rd_addr = {8'h00, row_q, dram_a[9:0], 2'b00};
				if (!row_open)
					report_error("column read with no preceding row activate");
				// column is zero-extended onto the address pins
				if (dram_a[11:10] !== 2'b00)
					report_mismatch("dram_a[11:10]", "00", $sformatf("%b", dram_a[11:10]));
				if (dram_mem.exists(rd_addr))
					q_next = dram_mem[rd_addr];
				else
				begin
					report_error($sformatf("read of DRAM address %h with no contents", rd_addr));
					q_next = 32'hdeadbeef;
				end
			end
			else
				row_open = 1'b0;
			@(posedge clk);
			#1;
			if (read_now)
				dram_q = q_next;
		end
	end

	// buffer write and done checker
	initial
	begin
		wrote_prev = 1'b0;
		done_prev = 1'b0;
		forever
		begin
			@(negedge clk);
			wrote_now = 1'b0;
			if (rst === 1'b0)
			begin
				check_port(1'b0, 1'b0, input_buffer_cen[0], input_buffer_wen[0],
					input_buffer_a[0], {160'b0, input_buffer_di[0]});
				check_port(1'b0, 1'b1, input_buffer_cen[1], input_buffer_wen[1],
					input_buffer_a[1], {160'b0, input_buffer_di[1]});
				check_port(1'b1, 1'b0, weight_buffer_cen[0], weight_buffer_wen[0],
					weight_buffer_a[0], weight_buffer_di[0]);
				check_port(1'b1, 1'b1, weight_buffer_cen[1], weight_buffer_wen[1],
					weight_buffer_a[1], weight_buffer_di[1]);
				if (done === 1'b1)
				begin
					if (!wrote_prev)
						report_error("done pulsed without a buffer write in the cycle before");
					if (done_prev)
						report_mismatch("done", "0", "1");
				end
			end
			done_prev = (done === 1'b1);
			wrote_prev = wrote_now;
		end
	end

	initial
	begin
		rst = 1'b1;
		start = 1'b0;
		kind = 1'b0;
		bank = 1'b0;
		dram_addr_start = '0;
		dram_addr_end = '0;
		buf_addr_start = '0;
		run_ok = 1'b1;
		load_testdata();
		@(negedge clk);
		check_idle_outputs();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_idle_outputs();
		for (tr = 0; tr < t_kind.size() && run_ok; tr++)
			run_transfer(tr, run_ok);
		if (exp_idx != e_kind.size())
			report_mismatch("buffer write count", $sformatf("%0d", e_kind.size()),
				$sformatf("%0d", exp_idx));
		$display("writes %0d, mismatches %0d, other errors %0d", write_count, mismatch_count,
			error_count);
		if (mismatch_count == 0 && error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/buffer_dma_testdata.txt ====
# M byte_addr word
# T kind bank buf_addr_start dram_addr_start dram_addr_end
# E kind bank buf_addr line (first word in the top bits)
# row 001 words for the input transfer
M 00001040 11a0c001
M 00001044 22b1c002
M 00001048 33c2c003
M 0000104c 44d3c004
M 00001050 55e4c005
M 00001054 66f5c006
M 00001058 7706c007
M 0000105c 8817c008
# row 023 words for the weight transfer
M 00023100 9a000101
M 00023104 9a000202
M 00023108 9a000303
M 0002310c 9a000404
M 00023110 9a000505
M 00023114 9a000606
M 00023118 9a000707
M 0002311c 9a000808
M 00023120 9a000909
M 00023124 9b001010
M 00023128 9b002020
M 0002312c 9b003030
M 00023130 9b004040
M 00023134 9b005050
M 00023138 9b006060
M 0002313c 9b007070
M 00023140 9b008080
M 00023144 9b009090
# row abc words for a single input line
M 00abc0f0 c0ffee01
M 00abc0f4 c0ffee02
M 00abc0f8 c0ffee03
M 00abc0fc c0ffee04
T 0 0 05 00001040 0000105c
T 1 1 3e 00023100 00023144
T 0 1 12 00abc0f0 00abc0fc
E 0 0 05 11a0c00122b1c00233c2c00344d3c004
E 0 0 06 55e4c00566f5c0067706c0078817c008
E 1 1 3e 9a0001019a0002029a0003039a0004049a0005059a0006069a0007079a0008089a000909
E 1 1 3f 9b0010109b0020209b0030309b0040409b0050509b0060609b0070709b0080809b009090
E 0 1 12 c0ffee01c0ffee02c0ffee03c0ffee04

// ==== verilog.f ====
logic/dma_pkg.sv
logic/dram_row_sequencer.sv
logic/line_packer.sv
logic/buffer_dma.sv
dv/tb_buffer_dma.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the buffer DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_buffer_dma -Mdir obj_dir -f verilog.f
./obj_dir/Vtb_buffer_dma > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
grep -q "Simulation passed" sim.log
